//--- sim.f
+incdir+src
src/alu_pkg.sv
src/alu_op_if.sv
src/cmd_decoder.sv
src/fix_unit.sv
src/int_float_converter.sv
src/int_sqrt.sv
src/result_collector.sv
src/alu_top.sv
bench/tb_clock.sv
bench/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run the testbench from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module alu_tb -Mdir build/obj -o alu_sim

./build/obj/alu_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

//--- bench/alu_tb.sv
`include "alu_consts.svh"

module alu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_cmds   = 400;
    localparam int max_cycles = num_cmds * 20 + 100;   // a command takes at most 19 cycles

    logic                     clk;
    logic                     rst;
    logic                     cmd_valid;
    logic [`CMD_WIDTH-1:0]    cmd_data;
    logic                     busy;
    logic                     resp_valid;
    logic [`RESULT_WIDTH-1:0] fix_result;
    logic [`ALU_WIDTH-1:0]    cvt_result;
    logic [`ALU_WIDTH-1:0]    sqrt_result;

    int          value_errors = 0;
    int          protocol_errors = 0;
    int          cycles = 0;
    logic [31:0] rand_state = 32'hf977054f;

    tb_clock #(.period_ns(10), .reset_cycles(5)) u_clock (.clk(clk), .rst(rst));

    alu_top uut (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_data    (cmd_data),
        .busy        (busy),
        .resp_valid  (resp_valid),
        .fix_result  (fix_result),
        .cvt_result  (cvt_result),
        .sqrt_result (sqrt_result)
    );

    // **********************************************************************
    // stimulus
    // **********************************************************************

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;   // callers use the upper bits since the low ones are weak
    endfunction

    // mostly random words with edge values for every unit mixed in
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        logic [31:0] m;
        r = next_random();
        m = next_random();
        case (r[31:28])
            4'd0:    return 32'h0;
            4'd1:    return 32'h8000_0000;
            4'd2:    return {m[31], 8'hff, m[22:1], 1'b1};            // NaN
            4'd3:    return {m[31], 8'hff, 23'd0};                    // infinity
            4'd4:    return {m[31], 8'd150 + 8'(r[27:24]), m[22:0]};  // around 2^31
            4'd5:    return {m[31], 8'd0, m[22:0]};                   // denormal
            4'd6:    return 32'hffff_ffff;
            4'd7:    return 32'(m[31:16]) * 32'(m[31:16]);            // perfect square
            4'd8:    return {m[31], 8'd127 + 8'(r[27:23]), m[22:0]};
            4'd9:    return 32'h7fff_ffff;
            4'd10:   return {{16{m[31]}}, m[31:16]};
            default: return m;
        endcase
    endfunction

    // **********************************************************************
    // reference model
    // **********************************************************************

    function automatic logic [63:0] model_fix(input alu_pkg::fix_mode_t m,
                                              input logic [31:0] a,
                                              input logic [31:0] b);
        longint sa;
        longint sb;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (m)
            alu_pkg::fix_add: return sa + sb;
            alu_pkg::fix_sub: return sa - sb;
            alu_pkg::fix_mul: return sa * sb;
            default:          return (sa * sb) >>> 16;
        endcase
    endfunction

    function automatic logic [31:0] model_i2f(input logic [31:0] x);
        longint      mag;
        int          e;
        logic [31:0] frac;
        if (x == 32'd0) return 32'd0;
        mag = longint'($signed(x));
        if (mag < 0) mag = -mag;
        e = 0;
        while ((mag >> (e + 1)) != 0) e++;   // e is the position of the leading one
        frac = (e >= 23) ? 32'(mag >> (e - 23)) : 32'(mag << (23 - e));
        return {x[31], 8'(127 + e), frac[22:0]};
    endfunction

    function automatic logic [31:0] model_f2i(input logic [31:0] x);
        longint mag;
        if (x[30:23] == 8'hff && x[22:0] != 23'd0) return 32'h7fff_ffff;
        if (x[30:23] < 8'd127) return 32'd0;
        if (x[30:23] >= 8'd158) return x[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        mag = (longint'({1'b1, x[22:0]}) << (x[30:23] - 8'd127)) >> 23;
        return x[31] ? 32'(-mag) : 32'(mag);
    endfunction

    function automatic logic [31:0] model_sqrt(input logic [31:0] x);
        logic [31:0] r;
        logic [31:0] t;
        r = 32'd0;
        for (int pos = 15; pos >= 0; pos--) begin
            t = r | (32'd1 << pos);
            if (64'(t) * 64'(t) <= 64'(x)) r = t;   // keep the bit if t squared still fits
        end
        return r;
    endfunction

    // **********************************************************************
    // checks
    // **********************************************************************

    task automatic check_fix(input string name, input logic [`RESULT_WIDTH-1:0] exp,
                             input logic [`RESULT_WIDTH-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_cvt(input string name, input logic [`ALU_WIDTH-1:0] exp,
                             input logic [`ALU_WIDTH-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_sqrt(input string name, input logic [`ALU_WIDTH-1:0] exp,
                              input logic [`ALU_WIDTH-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_idle(input string where);
        if (busy !== 1'b0 || resp_valid !== 1'b0) begin
            protocol_errors++;
            $display("busy or resp_valid is high %s", where);
        end
        check_fix({where, " fix"}, '0, fix_result);
        check_cvt({where, " cvt"}, '0, cvt_result);
        check_sqrt({where, " sqrt"}, '0, sqrt_result);
    endtask

    // drives one command on the current falling edge and follows it to its response
    task automatic run_command(input int idx);
        logic [31:0]              r0;
        logic [31:0]              r1;
        logic [31:0]              r2;
        logic [31:0]              r3;
        logic [31:0]              a;
        logic [31:0]              b;
        logic [31:0]              cv;
        logic [31:0]              sq;
        alu_pkg::unit_sel_t       sel;
        alu_pkg::fix_mode_t       fm;
        alu_pkg::cvt_mode_t       cm;
        logic [`RESULT_WIDTH-1:0] exp_fix;
        logic [`ALU_WIDTH-1:0]    exp_cvt;
        logic [`ALU_WIDTH-1:0]    exp_sqrt;
        int                       lat_exp;
        int                       n;
        bit                       seen;
        string                    name;
        r0 = next_random();
        r1 = next_random();
        r2 = next_random();
        r3 = next_random();
        sel = alu_pkg::unit_sel_t'(3'(r0[31:16] % 7 + 1));   // never an empty selection
        fm = alu_pkg::fix_mode_t'(r1[31:30]);
        cm = alu_pkg::cvt_mode_t'(r1[29]);
        a = pick_operand();
        b = pick_operand();
        cv = pick_operand();
        sq = pick_operand();
        exp_fix = sel.fix ? model_fix(fm, a, b) : '0;
        exp_cvt = !sel.cvt ? '0
                : (cm == alu_pkg::cvt_int_to_float) ? model_i2f(cv) : model_f2i(cv);
        exp_sqrt = sel.sqrt ? model_sqrt(sq) : '0;
        name = $sformatf("cmd %0d sel %b %s %s", idx, sel, fm.name(), cm.name());
        cmd_valid = 1'b1;
        cmd_data = {r3, sq, cv, b, a, r2[31:6], cm, fm, sel};   // unused bits carry noise
        lat_exp = sel.sqrt ? 18 : 3;
        n = 0;
        seen = 1'b0;
        while (!seen && n < lat_exp + 5) begin
            @(negedge clk);
            cmd_valid = 1'b0;
            n++;
            if (busy !== 1'b1) begin
                protocol_errors++;
                $display("busy is low %0d cycles into %s", n, name);
            end
            seen = (resp_valid === 1'b1);
        end
        if (!seen) begin
            protocol_errors++;
            $display("no resp_valid for %s within %0d cycles", name, n);
        end else begin
            if (n != lat_exp) begin
                protocol_errors++;
                $display("resp_valid for %s came after %0d cycles, not %0d", name, n, lat_exp);
            end
            check_fix({name, " fix"}, exp_fix, fix_result);
            check_cvt({name, " cvt"}, exp_cvt, cvt_result);
            check_sqrt({name, " sqrt"}, exp_sqrt, sqrt_result);
        end
        @(negedge clk);
        if (busy !== 1'b0 || resp_valid !== 1'b0) begin
            protocol_errors++;
            $display("busy or resp_valid still high one cycle after the response to %s", name);
        end
        if (seen) begin
            check_fix({name, " fix hold"}, exp_fix, fix_result);
            check_cvt({name, " cvt hold"}, exp_cvt, cvt_result);
            check_sqrt({name, " sqrt hold"}, exp_sqrt, sqrt_result);
        end
    endtask

    // **********************************************************************
    // run
    // **********************************************************************

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        cmd_valid = 1'b0;
        cmd_data = '0;
        repeat (2) @(negedge clk);
        check_idle("during reset");
        wait (rst === 1'b0);
        repeat (3) begin
            @(negedge clk);
            check_idle("after reset");
        end
        for (int i = 0; i < num_cmds; i++) begin
            run_command(i);
        end
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock.sv
module tb_clock #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // reset drops on a falling edge away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- src/alu_top.sv
`include "alu_consts.svh"

module alu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_valid,
    input  logic [`CMD_WIDTH-1:0]    cmd_data,
    output logic                     busy,
    output logic                     resp_valid,
    output logic [`RESULT_WIDTH-1:0] fix_result,
    output logic [`ALU_WIDTH-1:0]    cvt_result,
    output logic [`ALU_WIDTH-1:0]    sqrt_result
);

    alu_op_if fix_op ();
    alu_op_if cvt_op ();
    alu_op_if sqrt_op ();

    cmd_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_data  (cmd_data),
        .fix_op    (fix_op),
        .cvt_op    (cvt_op),
        .sqrt_op   (sqrt_op)
    );

    fix_unit            u_fix  (.clk(clk), .rst(rst), .op(fix_op));
    int_float_converter u_cvt  (.clk(clk), .rst(rst), .op(cvt_op));
    int_sqrt            u_sqrt (.clk(clk), .rst(rst), .op(sqrt_op));

    result_collector u_collector (
        .clk         (clk),
        .rst         (rst),
        .fix_op      (fix_op),
        .cvt_op      (cvt_op),
        .sqrt_op     (sqrt_op),
        .busy        (busy),
        .resp_valid  (resp_valid),
        .fix_result  (fix_result),
        .cvt_result  (cvt_result),
        .sqrt_result (sqrt_result)
    );

endmodule

//--- src/result_collector.sv
`include "alu_consts.svh"

module result_collector (
    input  logic                     clk,
    input  logic                     rst,
    alu_op_if.monitor                fix_op,
    alu_op_if.monitor                cvt_op,
    alu_op_if.monitor                sqrt_op,
    output logic                     busy,
    output logic                     resp_valid,
    output logic [`RESULT_WIDTH-1:0] fix_result,
    output logic [`ALU_WIDTH-1:0]    cvt_result,
    output logic [`ALU_WIDTH-1:0]    sqrt_result
);

    logic [2:0]               en_vec;     // fix, cvt, sqrt in unit_sel_t order
    logic [2:0]               done_vec;
    logic [2:0]               pending;
    logic [2:0]               pending_nxt;
    logic                     last_done;
    logic [`RESULT_WIDTH-1:0] fix_cap;
    logic [`ALU_WIDTH-1:0]    cvt_cap;
    logic [`ALU_WIDTH-1:0]    sqrt_cap;
    logic [`RESULT_WIDTH-1:0] fix_nxt;
    logic [`ALU_WIDTH-1:0]    cvt_nxt;
    logic [`ALU_WIDTH-1:0]    sqrt_nxt;

    assign en_vec      = {fix_op.en, cvt_op.en, sqrt_op.en};
    assign done_vec    = {fix_op.done, cvt_op.done, sqrt_op.done};
    assign pending_nxt = (pending | en_vec) & ~done_vec;
    assign last_done   = (pending != 3'b000) && (pending_nxt == 3'b000);

    // a result arriving on the final edge goes straight to the outputs
    assign fix_nxt  = fix_op.done  ? fix_op.result                : fix_cap;
    assign cvt_nxt  = cvt_op.done  ? cvt_op.result[`ALU_WIDTH-1:0]  : cvt_cap;
    assign sqrt_nxt = sqrt_op.done ? sqrt_op.result[`ALU_WIDTH-1:0] : sqrt_cap;

    // high from the request cycle through the response cycle
    assign busy = (|en_vec) | (|pending) | resp_valid;

    // a new command clears all captures so that unselected units read zero
    always_ff @(posedge clk) begin
        if (|en_vec) begin
            fix_cap  <= '0;
            cvt_cap  <= '0;
            sqrt_cap <= '0;
        end
        if (fix_op.done)  fix_cap  <= fix_op.result;
        if (cvt_op.done)  cvt_cap  <= cvt_op.result[`ALU_WIDTH-1:0];
        if (sqrt_op.done) sqrt_cap <= sqrt_op.result[`ALU_WIDTH-1:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending     <= 3'b000;
            resp_valid  <= 1'b0;
            fix_result  <= '0;
            cvt_result  <= '0;
            sqrt_result <= '0;
        end else begin
            pending    <= pending_nxt;
            resp_valid <= last_done;
            if (last_done) begin
                fix_result  <= fix_nxt;
                cvt_result  <= cvt_nxt;
                sqrt_result <= sqrt_nxt;
            end
        end
    end

    // the host raised cmd_valid while busy was high
    host_waits_on_busy: assert property (@(posedge clk) disable iff (rst)
        (|en_vec) |-> (pending == 3'b000));

endmodule

//--- src/int_sqrt.sv
`include "alu_consts.svh"

module int_sqrt (
    input  logic   clk,
    input  logic   rst,
    alu_op_if.unit op
);

    localparam int root_w = `ALU_WIDTH / 2;
    localparam int cnt_w  = $clog2(`SQRT_ITER);
    localparam logic [cnt_w-1:0] last_step = cnt_w'(`SQRT_ITER - 1);

    logic                  running;
    logic                  done_q;
    logic [cnt_w-1:0]      cnt;      // steps already taken
    logic [`ALU_WIDTH-1:0] x_q;      // radicand consumed two bits per step
    logic [`ALU_WIDTH-1:0] rem_q;
    logic [root_w-1:0]     root_q;

    logic [`ALU_WIDTH-1:0] src_x;
    logic [`ALU_WIDTH-1:0] src_rem;
    logic [root_w-1:0]     src_root;
    logic [`ALU_WIDTH-1:0] rem_sh;
    logic [`ALU_WIDTH-1:0] trial;
    logic [`ALU_WIDTH-1:0] rem_nxt;
    logic [root_w-1:0]     root_nxt;

    // the first step runs on the load edge straight from the request
    assign src_x    = op.en ? op.a : x_q;
    assign src_rem  = op.en ? '0 : rem_q;
    assign src_root = op.en ? '0 : root_q;

    assign rem_sh = {src_rem[`ALU_WIDTH-3:0], src_x[`ALU_WIDTH-1 -: 2]};
    assign trial  = {{(`ALU_WIDTH-root_w-2){1'b0}}, src_root, 2'b01};

    always_comb begin
        if (rem_sh >= trial) begin
            rem_nxt  = rem_sh - trial;
            root_nxt = {src_root[root_w-2:0], 1'b1};
        end else begin
            rem_nxt  = rem_sh;   // restore since the trial did not fit
            root_nxt = {src_root[root_w-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            done_q  <= 1'b0;
            cnt     <= '0;
            x_q     <= '0;
            rem_q   <= '0;
            root_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (op.en || running) begin
                x_q    <= src_x << 2;
                rem_q  <= rem_nxt;
                root_q <= root_nxt;
            end
            if (op.en) begin
                running <= 1'b1;
                cnt     <= cnt_w'(1);
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == last_step) begin
                    running <= 1'b0;
                    done_q  <= 1'b1;   // root_q holds the floor root from here on
                end
            end
        end
    end

    assign op.done   = done_q;
    assign op.result = `RESULT_WIDTH'(root_q);

    // the decoder must not issue a new root while one is in flight
    no_en_while_running: assert property (@(posedge clk) disable iff (rst)
        running |-> !op.en);

endmodule

//--- src/int_float_converter.sv
`include "alu_consts.svh"

module int_float_converter (
    input  logic   clk,
    input  logic   rst,
    alu_op_if.unit op
);

    // **********************************************************************
    // int32 to float32
    // **********************************************************************

    logic                  i_sign;
    logic [`ALU_WIDTH-1:0] i_mag;
    logic [4:0]            i_lead;   // position of the leading one
    logic [`ALU_WIDTH-1:0] i_norm;
    logic [`ALU_WIDTH-1:0] i2f_word;

    assign i_sign = op.a[31];
    assign i_mag  = i_sign ? (~op.a + 32'd1) : op.a;   // most negative input stays 2^31

    always_comb begin
        i_lead = 5'd0;
        for (int i = 0; i < `ALU_WIDTH; i++) begin
            if (i_mag[i]) begin
                i_lead = 5'(i);
            end
        end
    end

    assign i_norm   = i_mag << (5'd31 - i_lead);   // hidden one lands on bit 31
    assign i2f_word = (i_mag == '0) ? '0
                    : {i_sign, 8'd127 + {3'b000, i_lead}, i_norm[30:8]};   // low bits truncated

    // **********************************************************************
    // float32 to int32
    // **********************************************************************

    logic                  f_sign;
    logic [7:0]            f_exp;
    logic [22:0]           f_man;
    logic [7:0]            f_shift;
    logic [`ALU_WIDTH-1:0] f_sig;
    logic [`ALU_WIDTH-1:0] f_mag;
    logic [`ALU_WIDTH-1:0] f2i_word;

    assign f_sign  = op.a[31];
    assign f_exp   = op.a[30:23];
    assign f_man   = op.a[22:0];
    assign f_shift = f_exp - 8'd127;   // only used once the exponent is in 127..157
    assign f_sig   = {8'd0, 1'b1, f_man};
    assign f_mag   = (f_shift >= 8'd23) ? (f_sig << (f_shift - 8'd23))
                   : (f_sig >> (8'd23 - f_shift));

    always_comb begin
        if (f_exp == 8'hff && f_man != '0) begin
            f2i_word = 32'h7fff_ffff;                               // NaN
        end else if (f_exp < 8'd127) begin
            f2i_word = '0;                                          // magnitudes below one
        end else if (f_exp >= 8'd158) begin
            f2i_word = f_sign ? 32'h8000_0000 : 32'h7fff_ffff;      // 2^31 and beyond
        end else begin
            f2i_word = f_sign ? (~f_mag + 32'd1) : f_mag;
        end
    end

    logic                  done_q;
    logic [`ALU_WIDTH-1:0] result_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= op.en;
        end
    end

    always_ff @(posedge clk) begin
        if (op.en) begin
            result_q <= (alu_pkg::cvt_mode_t'(op.mode[0]) == alu_pkg::cvt_int_to_float)
                      ? i2f_word : f2i_word;
        end
    end

    assign op.done   = done_q;
    assign op.result = `RESULT_WIDTH'(result_q);

endmodule

//--- src/fix_unit.sv
`include "alu_consts.svh"

module fix_unit (
    input  logic   clk,
    input  logic   rst,
    alu_op_if.unit op
);

    logic signed [`RESULT_WIDTH-1:0] a_ext;
    logic signed [`RESULT_WIDTH-1:0] b_ext;
    logic signed [`RESULT_WIDTH-1:0] prod;
    logic        [`RESULT_WIDTH-1:0] value;
    logic        [`RESULT_WIDTH-1:0] result_q;
    logic                            done_q;

    // both operands are signed 32-bit values
    assign a_ext = `RESULT_WIDTH'(signed'(op.a));
    assign b_ext = `RESULT_WIDTH'(signed'(op.b));
    assign prod  = a_ext * b_ext;   // a 32 by 32 product always fits in 64 bits

    always_comb begin
        case (alu_pkg::fix_mode_t'(op.mode))
            alu_pkg::fix_add:     value = a_ext + b_ext;
            alu_pkg::fix_sub:     value = a_ext - b_ext;
            alu_pkg::fix_mul:     value = prod;
            alu_pkg::fix_mul_q16: value = prod >>> 16;   // drop the extra 16 fraction bits
            default:              value = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= op.en;
        end
    end

    always_ff @(posedge clk) begin
        if (op.en) begin
            result_q <= value;
        end
    end

    assign op.done   = done_q;
    assign op.result = result_q;

endmodule

//--- src/cmd_decoder.sv
`include "alu_consts.svh"

module cmd_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  logic [`CMD_WIDTH-1:0] cmd_data,
    alu_op_if.issue               fix_op,
    alu_op_if.issue               cvt_op,
    alu_op_if.issue               sqrt_op
);

    alu_pkg::unit_sel_t    sel;
    logic [2:0]            en_q;   // fix, cvt, sqrt in unit_sel_t order
    alu_pkg::fix_mode_t    fix_mode_q;
    alu_pkg::cvt_mode_t    cvt_mode_q;
    logic [`ALU_WIDTH-1:0] fix_a_q;
    logic [`ALU_WIDTH-1:0] fix_b_q;
    logic [`ALU_WIDTH-1:0] cvt_in_q;
    logic [`ALU_WIDTH-1:0] sqrt_in_q;

    assign sel = alu_pkg::unit_sel_t'(cmd_data[2:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en_q <= 3'b000;
        end else begin
            en_q <= cmd_valid ? {sel.fix, sel.cvt, sel.sqrt} : 3'b000;   // strobe lasts one cycle
        end
    end

    // operands and modes are taken from the accepted command
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            fix_mode_q <= alu_pkg::fix_mode_t'(cmd_data[4:3]);
            cvt_mode_q <= alu_pkg::cvt_mode_t'(cmd_data[5]);
            fix_a_q    <= cmd_data[63:32];
            fix_b_q    <= cmd_data[95:64];
            cvt_in_q   <= cmd_data[127:96];
            sqrt_in_q  <= cmd_data[159:128];
        end
    end

    assign fix_op.en    = en_q[2];
    assign fix_op.mode  = fix_mode_q;
    assign fix_op.a     = fix_a_q;
    assign fix_op.b     = fix_b_q;
    assign cvt_op.en    = en_q[1];
    assign cvt_op.mode  = {1'b0, cvt_mode_q};
    assign cvt_op.a     = cvt_in_q;
    assign cvt_op.b     = '0;   // the converter has a single input
    assign sqrt_op.en   = en_q[0];
    assign sqrt_op.mode = '0;
    assign sqrt_op.a    = sqrt_in_q;
    assign sqrt_op.b    = '0;

    // a request never repeats on the next cycle, since the host waits on busy
    en_single_cycle: assert property (@(posedge clk) disable iff (rst)
        (en_q & $past(en_q)) == 3'b000);

endmodule

//--- src/alu_op_if.sv
`include "alu_consts.svh"

interface alu_op_if;

    logic                     en;       // one-cycle request strobe
    logic [1:0]               mode;
    logic [`ALU_WIDTH-1:0]    a;
    logic [`ALU_WIDTH-1:0]    b;
    logic                     done;     // one-cycle completion strobe
    logic [`RESULT_WIDTH-1:0] result;   // narrower results arrive zero-extended

    // the decoder issues a request
    modport issue (output en, mode, a, b);

    // a unit takes the request and answers
    modport unit (input en, mode, a, b, output done, result);

    // the collector watches requests and answers
    modport monitor (input en, done, result);

endinterface

//--- src/alu_pkg.sv
package alu_pkg;

    // **********************************************************************
    // unit modes
    // **********************************************************************

    // fixed-point operation carried on the two mode bits of a request
    typedef enum logic [1:0] {
        fix_add     = 2'b00,
        fix_sub     = 2'b01,
        fix_mul     = 2'b10,
        fix_mul_q16 = 2'b11   // product scaled back by 2^16
    } fix_mode_t;

    // conversion direction carried on mode bit 0 of a converter request
    typedef enum logic {
        cvt_int_to_float = 1'b0,
        cvt_float_to_int = 1'b1
    } cvt_mode_t;

    // **********************************************************************
    // unit selection in bits 2:0 of a command
    // **********************************************************************

    typedef struct packed {
        logic fix;    // bit 2
        logic cvt;    // bit 1
        logic sqrt;   // bit 0
    } unit_sel_t;

endpackage

//--- src/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// **********************************************************************
// datapath widths
// **********************************************************************

`define ALU_WIDTH 32      // width of every operand on a unit request
`define CMD_WIDTH 192     // one host command word
`define RESULT_WIDTH 64   // unit result field that holds the full product

// **********************************************************************
// square root
// **********************************************************************

`define SQRT_ITER 16      // half of ALU_WIDTH as each step yields one result bit

`endif
